// File: common/mem_pkg.sv
package mem_pkg;

    // burst memory geometry
    localparam int ADDR_WIDTH     = 32;
    localparam int BEAT_WIDTH     = 64;
    localparam int BEATS_PER_LINE = 4;
    localparam int LINE_BYTES     = 32;

    localparam int LINE_WIDTH     = BEATS_PER_LINE * BEAT_WIDTH;  // 256 data bits
    localparam int BEAT_CNT_WIDTH = $clog2(BEATS_PER_LINE);

    // beat k sits in data[64k +: 64]
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;   // line address
        logic [LINE_WIDTH-1:0] data;
    } line_t;

endpackage : mem_pkg

// File: common/fetch_pkg.sv
package fetch_pkg;

    localparam int INST_WIDTH     = 32;
    localparam int WORDS_PER_LINE = 8;
    localparam int WORD_IDX_WIDTH = $clog2(WORDS_PER_LINE);

    // one fetched instruction with its pc
    typedef struct packed {
        logic [31:0]           pc;
        logic [INST_WIDTH-1:0] inst;
    } fetch_entry_t;

endpackage : fetch_pkg

// File: hdl/fetch_request.sv
module fetch_request #(
    parameter logic [mem_pkg::ADDR_WIDTH-1:0] RESET_PC = 32'h1eceb000
) (
    input   logic                           clk,
    input   logic                           rst,

    input   logic                           bmem_ready_i,
    input   logic                           line_take_i,

    output  logic                           bmem_read_o,
    output  logic   [mem_pkg::ADDR_WIDTH-1:0] bmem_addr_o
);

    import mem_pkg::*;

    logic   [ADDR_WIDTH-1:0]    line_pc;
    logic                       outstanding;    // read issued, line not yet taken
    logic                       armed;          // low for one cycle out of reset

    assign bmem_read_o = armed && bmem_ready_i && !outstanding;
    assign bmem_addr_o = line_pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            line_pc     <= RESET_PC;
            outstanding <= 1'b0;
            armed       <= 1'b0;
        end else begin
            armed <= 1'b1;
            if (bmem_read_o) begin
                line_pc     <= line_pc + ADDR_WIDTH'(LINE_BYTES);  // next line
                outstanding <= 1'b1;
            end else if (line_take_i) begin
                outstanding <= 1'b0;    // splitter has the line
            end
        end
    end

endmodule : fetch_request

// File: hdl/burst_assembler.sv
module burst_assembler (
    input   logic                               clk,
    input   logic                               rst,

    input   logic   [mem_pkg::ADDR_WIDTH-1:0]   bmem_raddr_i,
    input   logic   [mem_pkg::BEAT_WIDTH-1:0]   bmem_rdata_i,
    input   logic                               bmem_rvalid_i,
    input   logic                               line_take_i,

    output  mem_pkg::line_t                     line_o,
    output  logic                               line_valid_o
);

    import mem_pkg::*;

    localparam logic [BEAT_CNT_WIDTH-1:0] LAST_BEAT = BEAT_CNT_WIDTH'(BEATS_PER_LINE - 1);

    logic   [BEAT_CNT_WIDTH-1:0]    beat_cnt;
    line_t                          line_q;
    logic                           line_valid;

    assign line_o       = line_q;
    assign line_valid_o = line_valid;

    // line payload
    always_ff @(posedge clk) begin
        if (bmem_rvalid_i) begin
            line_q.data[beat_cnt*BEAT_WIDTH +: BEAT_WIDTH] <= bmem_rdata_i;
            if (beat_cnt == '0) begin
                line_q.addr <= bmem_raddr_i;    // address from first beat
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt   <= '0;
            line_valid <= 1'b0;
        end else begin
            if (bmem_rvalid_i) begin
                beat_cnt <= beat_cnt + 1'b1;    // wraps after last beat
            end
            if (bmem_rvalid_i && beat_cnt == LAST_BEAT) begin
                line_valid <= 1'b1;
            end else if (line_take_i) begin
                line_valid <= 1'b0;
            end
        end
    end

endmodule : burst_assembler

// File: hdl/line_splitter.sv
module line_splitter (
    input   logic                       clk,
    input   logic                       rst,

    input   mem_pkg::line_t             line_i,
    input   logic                       line_valid_i,
    input   logic                       queue_full_i,

    output  logic                       line_take_o,
    output  fetch_pkg::fetch_entry_t    entry_o,
    output  logic                       entry_push_o
);

    import mem_pkg::*;
    import fetch_pkg::*;

    localparam logic [WORD_IDX_WIDTH-1:0] LAST_WORD = WORD_IDX_WIDTH'(WORDS_PER_LINE - 1);

    line_t                          line_q;
    logic                           busy;
    logic   [WORD_IDX_WIDTH-1:0]    word_idx;

    assign line_take_o  = !busy && line_valid_i;
    assign entry_push_o = busy && !queue_full_i;   // stall on full queue

    always_comb begin
        entry_o.pc   = line_q.addr + ADDR_WIDTH'({word_idx, 2'b00});
        entry_o.inst = line_q.data[word_idx*INST_WIDTH +: INST_WIDTH];
    end

    always_ff @(posedge clk) begin
        if (line_take_o) begin
            line_q <= line_i;   // own copy frees the assembler
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            word_idx <= '0;
        end else begin
            if (line_take_o) begin
                busy     <= 1'b1;
                word_idx <= '0;
            end else if (entry_push_o) begin
                word_idx <= word_idx + 1'b1;
                if (word_idx == LAST_WORD) begin
                    busy <= 1'b0;   // line drained
                end
            end
        end
    end

endmodule : line_splitter

// File: hdl/fetch_queue.sv
module fetch_queue #(
    parameter int QUEUE_DEPTH = 16
) (
    input   logic                       clk,
    input   logic                       rst,

    input   fetch_pkg::fetch_entry_t    entry_i,
    input   logic                       push_i,
    input   logic                       pop_i,

    output  fetch_pkg::fetch_entry_t    entry_o,
    output  logic                       full_o,
    output  logic                       empty_o
);

    import fetch_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    fetch_entry_t           mem [QUEUE_DEPTH];
    logic   [PTR_W-1:0]     wr_ptr;
    logic   [PTR_W-1:0]     rd_ptr;
    logic   [PTR_W:0]       count;
    logic                   do_push;
    logic                   do_pop;

    assign full_o  = (count == (PTR_W+1)'(QUEUE_DEPTH));
    assign empty_o = (count == '0);
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;    // pop on empty ignored
    assign entry_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= entry_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

endmodule : fetch_queue

// File: hdl/ifetch_top.sv
module ifetch_top #(
    parameter logic [mem_pkg::ADDR_WIDTH-1:0] RESET_PC    = 32'h1eceb000,
    parameter int                             QUEUE_DEPTH = 16
) (
    input   logic                               clk,
    input   logic                               rst,

    output  logic   [mem_pkg::ADDR_WIDTH-1:0]   bmem_addr_o,
    output  logic                               bmem_read_o,
    input   logic                               bmem_ready_i,

    input   logic   [mem_pkg::ADDR_WIDTH-1:0]   bmem_raddr_i,
    input   logic   [mem_pkg::BEAT_WIDTH-1:0]   bmem_rdata_i,
    input   logic                               bmem_rvalid_i,

    output  fetch_pkg::fetch_entry_t            fetch_o,
    output  logic                               fetch_valid_o,
    input   logic                               fetch_dequeue_i
);

    import mem_pkg::*;
    import fetch_pkg::*;

    line_t          line;
    logic           line_valid;
    logic           line_take;
    fetch_entry_t   entry;
    logic           entry_push;
    logic           queue_full;
    logic           queue_empty;

    assign fetch_valid_o = !queue_empty;

    fetch_request #(
        .RESET_PC(RESET_PC)
    ) fetch_request_i (
        .clk(clk),
        .rst(rst),
        .bmem_ready_i(bmem_ready_i),
        .line_take_i(line_take),
        .bmem_read_o(bmem_read_o),
        .bmem_addr_o(bmem_addr_o)
    );

    burst_assembler burst_assembler_i (
        .clk(clk),
        .rst(rst),
        .bmem_raddr_i(bmem_raddr_i),
        .bmem_rdata_i(bmem_rdata_i),
        .bmem_rvalid_i(bmem_rvalid_i),
        .line_take_i(line_take),
        .line_o(line),
        .line_valid_o(line_valid)
    );

    line_splitter line_splitter_i (
        .clk(clk),
        .rst(rst),
        .line_i(line),
        .line_valid_i(line_valid),
        .queue_full_i(queue_full),
        .line_take_o(line_take),
        .entry_o(entry),
        .entry_push_o(entry_push)
    );

    fetch_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) fetch_queue_i (
        .clk(clk),
        .rst(rst),
        .entry_i(entry),
        .push_i(entry_push),
        .pop_i(fetch_dequeue_i),
        .entry_o(fetch_o),
        .full_o(queue_full),
        .empty_o(queue_empty)
    );

endmodule : ifetch_top

// File: verif/tb_ifetch_top.sv
module tb_ifetch_top;

    timeunit 1ns;
    timeprecision 1ps;

    import mem_pkg::*;
    import fetch_pkg::*;

    localparam logic [31:0] RESET_PC        = 32'h1eceb000;  // DUT default
    localparam logic [31:0] INST_KEY        = 32'hdeadbeef;
    localparam int unsigned CLK_PERIOD      = 100;
    localparam int unsigned NUM_INSTS       = 64;
    localparam int unsigned CYCLES_PER_INST = 40;
    localparam int unsigned WATCHDOG_NS     = NUM_INSTS * CYCLES_PER_INST * CLK_PERIOD;

    logic                       clk;
    logic                       rst;
    logic   [ADDR_WIDTH-1:0]    bmem_addr_o;
    logic                       bmem_read_o;
    logic                       bmem_ready_i;
    logic   [ADDR_WIDTH-1:0]    bmem_raddr_i;
    logic   [BEAT_WIDTH-1:0]    bmem_rdata_i;
    logic                       bmem_rvalid_i;
    fetch_entry_t               fetch_o;
    logic                       fetch_valid_o;
    logic                       fetch_dequeue_i;

    logic   [31:0]  rng_state = 32'hb259;
    logic   [31:0]  next_read_addr;
    logic   [31:0]  expect_pc;
    logic   [31:0]  burst_addr;     // line being returned by the memory model
    int unsigned    beats_left;
    int unsigned    beat_idx;
    int unsigned    gap;            // idle cycles before the next beat
    int unsigned    checked_count;
    int unsigned    reset_edges;
    bit             first_after_reset;

    ifetch_top dut0 (
        .clk(clk),
        .rst(rst),
        .bmem_addr_o(bmem_addr_o),
        .bmem_read_o(bmem_read_o),
        .bmem_ready_i(bmem_ready_i),
        .bmem_raddr_i(bmem_raddr_i),
        .bmem_rdata_i(bmem_rdata_i),
        .bmem_rvalid_i(bmem_rvalid_i),
        .fetch_o(fetch_o),
        .fetch_valid_o(fetch_valid_o),
        .fetch_dequeue_i(fetch_dequeue_i)
    );

    function automatic int unsigned rand_below(input int unsigned n);
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state % n;
    endfunction

    function automatic logic [31:0] inst_at(input logic [31:0] addr);
        return addr ^ INST_KEY;
    endfunction

    // beat k holds words 2k and 2k+1 of the line
    function automatic logic [BEAT_WIDTH-1:0] beat_data(input logic [31:0] line_addr,
                                                        input int unsigned beat);
        logic [31:0] lo_addr;
        lo_addr = line_addr + 32'(8 * beat);
        return {inst_at(lo_addr + 32'd4), inst_at(lo_addr)};
    endfunction

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic fail_value(input string msg);
        $display("FAILED at %0d ns: %s", $time, msg);
        abort_run();
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog timeout: only %0d of %0d instructions checked",
                 checked_count, NUM_INSTS);
        abort_run();
    end

    // check sampled outputs then drive memory and consumer
    always @(posedge clk) begin
        if (rst) begin
            if (reset_edges != 0) begin     // state still unknown before first edge
                assert (!bmem_read_o) else fail_value("bmem_read_o high during reset");
                assert (!fetch_valid_o) else fail_value("fetch_valid_o high during reset");
            end
            reset_edges++;
            first_after_reset = 1'b1;
        end else begin
            if (first_after_reset) begin
                assert (!bmem_read_o) else fail_value("bmem_read_o high right after reset");
                assert (!fetch_valid_o) else fail_value("fetch_valid_o high right after reset");
                first_after_reset = 1'b0;
            end
            if (bmem_read_o) begin
                assert (bmem_ready_i) else fail_value("read strobe while memory not ready");
                assert (beats_left == 0)
                    else fail_value("read strobe while an earlier burst is still pending");
                assert (bmem_addr_o == next_read_addr)
                    else fail_value($sformatf("read address %h, expected %h",
                                              bmem_addr_o, next_read_addr));
                next_read_addr += 32'(LINE_BYTES);
            end
            if (fetch_valid_o && fetch_dequeue_i) begin
                assert (fetch_o.pc == expect_pc)
                    else fail_value($sformatf("popped pc %h, expected %h", fetch_o.pc, expect_pc));
                assert (fetch_o.inst == inst_at(expect_pc))
                    else fail_value($sformatf("inst %h at pc %h, expected %h",
                                              fetch_o.inst, expect_pc, inst_at(expect_pc)));
                expect_pc += 32'd4;
                checked_count++;
            end
        end

        bmem_rvalid_i <= 1'b0;
        if (beats_left != 0) begin
            if (gap != 0) begin
                gap--;
            end else begin
                bmem_rvalid_i <= 1'b1;
                bmem_raddr_i  <= burst_addr;
                bmem_rdata_i  <= beat_data(burst_addr, beat_idx);
                beat_idx++;
                beats_left--;
                gap = rand_below(3);
            end
        end
        if (!rst && bmem_read_o) begin
            burst_addr = bmem_addr_o;
            beats_left = BEATS_PER_LINE;
            beat_idx   = 0;
            gap        = rand_below(8);     // first-beat latency
        end
        bmem_ready_i    <= (rand_below(4) != 0);
        fetch_dequeue_i <= (rand_below(3) != 0);
    end

    initial begin
        rst             = 1'b1;
        bmem_ready_i    = 1'b0;
        bmem_raddr_i    = '0;
        bmem_rdata_i    = '0;
        bmem_rvalid_i   = 1'b0;
        fetch_dequeue_i = 1'b0;
        next_read_addr  = RESET_PC;
        expect_pc       = RESET_PC;
        beats_left      = 0;
        beat_idx        = 0;
        gap             = 0;
        checked_count   = 0;
        reset_edges     = 0;
        first_after_reset = 1'b0;

        repeat (4) @(posedge clk);
        rst <= 1'b0;

        wait (checked_count == NUM_INSTS);
        @(negedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule : tb_ifetch_top

// File: ifetch.f
common/mem_pkg.sv
common/fetch_pkg.sv
hdl/fetch_request.sv
hdl/burst_assembler.sv
hdl/line_splitter.sv
hdl/fetch_queue.sv
hdl/ifetch_top.sv
verif/tb_ifetch_top.sv
